// ==== dm_pkg.sv ====
/*
 * debug module shared definitions: bus widths, register indices,
 * dmcontrol bit positions, abstract command constants and command word layout
 */
`default_nettype none

package dm_pkg;

    // bus widths
    // the wishbone address is a register index, not a byte address
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;

    // debug module register indices
    localparam logic [ADDR_W-1:0] ADDR_DATA0     = 8'h04;
    localparam logic [ADDR_W-1:0] ADDR_DATA1     = 8'h05;
    localparam logic [ADDR_W-1:0] ADDR_DMCONTROL = 8'h10;
    localparam logic [ADDR_W-1:0] ADDR_COMMAND   = 8'h17;

    // dmcontrol bits that leave the design
    localparam int CTRL_HALTREQ   = 31;
    localparam int CTRL_RESUMEREQ = 30;
    localparam int CTRL_NDMRESET  = 1;
    localparam int CTRL_DMACTIVE  = 0;

    // abstract command type for access memory
    localparam logic [7:0] CMDTYPE_ACCESS_MEM = 8'd2;

    // aamsize code for a 32 bit access
    localparam logic [2:0] AAMSIZE_32 = 3'd2;

    // abstract command word, msb first
    // only the access memory decode is kept
    typedef struct packed {
        // 31:24
        logic [7:0]  cmdtype;
        // 23, virtual addressing request
        logic        aamvirtual;
        // 22:20, access size
        logic [2:0]  aamsize;
        // 19
        logic        aampostincrement;
        // 18:17
        logic [1:0]  reserved_hi;
        // 16, set for a memory write
        logic        write;
        // 15:0, target specific and unused here
        logic [15:0] reserved_lo;
    } command_t;

endpackage

`default_nettype wire

// ==== dm_reg_if.sv ====
/*
 * register request channel between the wishbone slave and the register file
 */
`timescale 1ns/1ps
`default_nettype none

interface dm_reg_if;

    // one cycle request pulse from the bus side
    logic                       req;
    logic                       we;
    logic [dm_pkg::ADDR_W-1:0]  addr;
    logic [dm_pkg::DATA_W-1:0]  wdata;

    // read data and completion from the register side
    // done may come with req or any later cycle
    logic [dm_pkg::DATA_W-1:0]  rdata;
    logic                       done;

    // wishbone slave side
    modport bus (output req, output we, output addr, output wdata,
                 input rdata, input done);

    // register file side
    modport regs (input req, input we, input addr, input wdata,
                  output rdata, output done);

endinterface

`default_nettype wire

// ==== dm_mem_if.sv ====
/*
 * abstract memory access channel between the register file and the sequencer
 */
`timescale 1ns/1ps
`default_nettype none

interface dm_mem_if;

    // one cycle start pulse with the access description
    logic                       start;
    logic                       write;
    logic [dm_pkg::DATA_W-1:0]  addr;
    logic [dm_pkg::DATA_W-1:0]  wdata;

    // one cycle done pulse, rdata valid with it on reads
    logic [dm_pkg::DATA_W-1:0]  rdata;
    logic                       done;

    // register file side
    modport ctrl (output start, output write, output addr, output wdata,
                  input rdata, input done);

    // sequencer side
    modport seq (input start, input write, input addr, input wdata,
                 output rdata, output done);

endinterface

`default_nettype wire

// ==== dm_wb_slave.sv ====
/*
 * wishbone classic slave for the debug module registers
 * fsm with idle, wait-for-done and acknowledge states, registered ack and read data
 */
`timescale 1ns/1ps
`default_nettype none

module dm_wb_slave (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [dm_pkg::ADDR_W-1:0]  wb_adr_i,
    input  logic [dm_pkg::DATA_W-1:0]  wb_dat_i,
    output logic [dm_pkg::DATA_W-1:0]  wb_dat_o,
    output logic                       wb_ack_o,
    dm_reg_if.bus                      reg_bus
);

    // fsm encoding
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_ACK  = 2'd2;

    logic [1:0] state_q;
    logic       bus_active;

    assign bus_active = wb_cyc_i && wb_stb_i;

    // a single request per bus cycle, only from idle
    // ack is always low in idle, so a new cycle is never taken while acking
    assign reg_bus.req   = (state_q == ST_IDLE) && bus_active;
    assign reg_bus.we    = wb_we_i;
    assign reg_bus.addr  = wb_adr_i;
    assign reg_bus.wdata = wb_dat_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q  <= ST_IDLE;
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (reg_bus.req)
                    begin
                        if (reg_bus.done)
                        begin
                            // plain register access, ack on the next cycle
                            state_q  <= ST_ACK;
                            wb_ack_o <= 1'b1;
                            wb_dat_o <= reg_bus.rdata;
                        end
                        else
                        begin
                            // memory access in flight
                            state_q <= ST_WAIT;
                        end
                    end
                end

                ST_WAIT:
                begin
                    if (reg_bus.done)
                    begin
                        // skip the ack if the master already gave up the cycle
                        if (bus_active)
                        begin
                            state_q  <= ST_ACK;
                            wb_ack_o <= 1'b1;
                            wb_dat_o <= reg_bus.rdata;
                        end
                        else
                        begin
                            state_q <= ST_IDLE;
                        end
                    end
                end

                ST_ACK:
                begin
                    // hold ack until the master ends the cycle
                    if (!bus_active)
                    begin
                        state_q  <= ST_IDLE;
                        wb_ack_o <= 1'b0;
                    end
                end

                default:
                begin
                    state_q  <= ST_IDLE;
                    wb_ack_o <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dm_regfile.sv ====
/*
 * debug module registers data0, data1, dmcontrol and command
 * address decode, dmcontrol outputs and access memory command decode
 */
`timescale 1ns/1ps
`default_nettype none

module dm_regfile (
    input  logic        clk_i,
    input  logic        rst_i,
    dm_reg_if.regs      reg_bus,
    dm_mem_if.ctrl      mem,
    output logic        haltreq_o,
    output logic        resumereq_o,
    output logic        ndmreset_o,
    output logic        dmactive_o
);

    logic [dm_pkg::DATA_W-1:0] data0_q;
    logic [dm_pkg::DATA_W-1:0] data1_q;
    logic [dm_pkg::DATA_W-1:0] dmcontrol_q;
    dm_pkg::command_t          command_q;

    // decoded bus write strobes
    logic              wr_data0;
    logic              wr_data1;
    logic              wr_dmcontrol;
    logic              wr_command;

    // incoming command word seen through the command layout
    dm_pkg::command_t  cmd_in;
    logic              cmd_supported;

    assign wr_data0     = reg_bus.req && reg_bus.we && (reg_bus.addr == dm_pkg::ADDR_DATA0);
    assign wr_data1     = reg_bus.req && reg_bus.we && (reg_bus.addr == dm_pkg::ADDR_DATA1);
    assign wr_dmcontrol = reg_bus.req && reg_bus.we
                          && (reg_bus.addr == dm_pkg::ADDR_DMCONTROL);
    assign wr_command   = reg_bus.req && reg_bus.we && (reg_bus.addr == dm_pkg::ADDR_COMMAND);

    assign cmd_in        = dm_pkg::command_t'(reg_bus.wdata);
    // only 32 bit access memory is executed, anything else is just stored
    assign cmd_supported = (cmd_in.cmdtype == dm_pkg::CMDTYPE_ACCESS_MEM)
                           && (cmd_in.aamsize == dm_pkg::AAMSIZE_32);

    // kick the sequencer, data1 holds the address and data0 the write data
    assign mem.start = wr_command && cmd_supported;
    assign mem.write = cmd_in.write;
    assign mem.addr  = data1_q;
    assign mem.wdata = data0_q;

    // immediate answer unless a memory access was started
    assign reg_bus.done = (reg_bus.req && !mem.start) || mem.done;

    // read mux, unknown indices read as zero
    always_comb
    begin
        case (reg_bus.addr)
            dm_pkg::ADDR_DATA0:     reg_bus.rdata = data0_q;
            dm_pkg::ADDR_DATA1:     reg_bus.rdata = data1_q;
            dm_pkg::ADDR_DMCONTROL: reg_bus.rdata = dmcontrol_q;
            dm_pkg::ADDR_COMMAND:   reg_bus.rdata = command_q;
            default:                reg_bus.rdata = '0;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            data0_q     <= '0;
            data1_q     <= '0;
            dmcontrol_q <= '0;
            command_q   <= '0;
        end
        else
        begin
            // data0 is fed by the bus and by memory read results
            if (wr_data0)
            begin
                data0_q <= reg_bus.wdata;
            end
            else if (mem.done && !command_q.write)
            begin
                data0_q <= mem.rdata;
            end

            if (wr_data1)
            begin
                data1_q <= reg_bus.wdata;
            end

            if (wr_dmcontrol)
            begin
                dmcontrol_q <= reg_bus.wdata;
            end

            // stored for every command, the write bit steers the data0 update
            if (wr_command)
            begin
                command_q <= cmd_in;
            end
        end
    end

    // dmcontrol fields towards the hart
    assign haltreq_o   = dmcontrol_q[dm_pkg::CTRL_HALTREQ];
    assign resumereq_o = dmcontrol_q[dm_pkg::CTRL_RESUMEREQ];
    assign ndmreset_o  = dmcontrol_q[dm_pkg::CTRL_NDMRESET];
    assign dmactive_o  = dmcontrol_q[dm_pkg::CTRL_DMACTIVE];

endmodule

`default_nettype wire

// ==== dm_mem_access.sv ====
/*
 * abstract memory access sequencer for the instruction memory
 * one read or write per start, fixed wait, then done with the read word
 */
`timescale 1ns/1ps
`default_nettype none

module dm_mem_access #(
    parameter int MEM_WAIT_CYCLES = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    dm_mem_if.seq                      mem,
    output logic [dm_pkg::DATA_W-1:0]  imem_addr_o,
    output logic [dm_pkg::DATA_W-1:0]  imem_wdata_o,
    output logic                       imem_we_o,
    input  logic [dm_pkg::DATA_W-1:0]  imem_rdata_i
);

    // wait counter runs 0 .. MEM_WAIT_CYCLES-1
    localparam int CNT_W = (MEM_WAIT_CYCLES > 1) ? $clog2(MEM_WAIT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MEM_WAIT_CYCLES - 1);

    logic                       busy_q;
    logic [CNT_W-1:0]           cnt_q;
    logic                       write_q;
    logic                       done_q;
    logic [dm_pkg::DATA_W-1:0]  rdata_q;

    assign mem.done  = done_q;
    assign mem.rdata = rdata_q;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            busy_q       <= 1'b0;
            cnt_q        <= '0;
            write_q      <= 1'b0;
            done_q       <= 1'b0;
            rdata_q      <= '0;
            imem_addr_o  <= '0;
            imem_wdata_o <= '0;
            imem_we_o    <= 1'b0;
        end
        else
        begin
            // single cycle pulses
            imem_we_o <= 1'b0;
            done_q    <= 1'b0;

            if (mem.start)
            begin
                // address and data stay on the memory for the whole access
                busy_q       <= 1'b1;
                cnt_q        <= '0;
                write_q      <= mem.write;
                imem_addr_o  <= mem.addr;
                imem_wdata_o <= mem.wdata;
                imem_we_o    <= mem.write;
            end
            else if (busy_q)
            begin
                if (cnt_q == CNT_LAST)
                begin
                    // wait over, done shows up in the next cycle
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                    if (!write_q)
                    begin
                        rdata_q <= imem_rdata_i;
                    end
                end
                else
                begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dm_top.sv ====
/*
 * debug module top: wishbone slave, register file and memory access sequencer
 */
`timescale 1ns/1ps
`default_nettype none

module dm_top #(
    parameter int MEM_WAIT_CYCLES = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_i,

    // wishbone classic slave
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [dm_pkg::ADDR_W-1:0]  wb_adr_i,
    input  logic [dm_pkg::DATA_W-1:0]  wb_dat_i,
    output logic [dm_pkg::DATA_W-1:0]  wb_dat_o,
    output logic                       wb_ack_o,

    // instruction memory
    output logic [dm_pkg::DATA_W-1:0]  imem_addr_o,
    output logic                       imem_we_o,
    output logic [dm_pkg::DATA_W-1:0]  imem_wdata_o,
    input  logic [dm_pkg::DATA_W-1:0]  imem_rdata_i,

    // dmcontrol fields
    output logic                       haltreq_o,
    output logic                       resumereq_o,
    output logic                       ndmreset_o,
    output logic                       dmactive_o
);

    dm_reg_if reg_if ();
    dm_mem_if mem_if ();

    // bus cycles in, register requests out
    dm_wb_slave u_wb_slave (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .reg_bus  (reg_if.bus)
    );

    dm_regfile u_regfile (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .reg_bus     (reg_if.regs),
        .mem         (mem_if.ctrl),
        .haltreq_o   (haltreq_o),
        .resumereq_o (resumereq_o),
        .ndmreset_o  (ndmreset_o),
        .dmactive_o  (dmactive_o)
    );

    // wait length is set here only
    dm_mem_access #(
        .MEM_WAIT_CYCLES (MEM_WAIT_CYCLES)
    ) u_mem_access (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem          (mem_if.seq),
        .imem_addr_o  (imem_addr_o),
        .imem_wdata_o (imem_wdata_o),
        .imem_we_o    (imem_we_o),
        .imem_rdata_i (imem_rdata_i)
    );

endmodule

`default_nettype wire

// ==== dm_props.sv ====
/*
 * wishbone ack properties, bound into the slave
 */
`timescale 1ns/1ps
`default_nettype none

module dm_props (
    input  logic clk_i,
    input  logic rst_i,
    input  logic wb_cyc_i,
    input  logic wb_stb_i,
    input  logic wb_ack_i
);

    // number of property failures so far
    int fail_count = 0;

    // ack is registered, so it only follows a cycle with cyc and stb high
    ack_needs_cycle: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i)
    )
    else
    begin
        fail_count++;
        $error("ack high without a preceding bus cycle");
    end

    // master drops cyc, ack is gone one cycle later
    ack_falls_after_cyc: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !wb_cyc_i |=> !wb_ack_i
    )
    else
    begin
        fail_count++;
        $error("ack did not fall after cyc dropped");
    end

    // cleared by reset
    ack_low_after_reset: assert property (
        @(posedge clk_i)
        rst_i |=> !wb_ack_i
    )
    else
    begin
        fail_count++;
        $error("ack high after reset");
    end

endmodule

bind dm_wb_slave dm_props u_props (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_i (wb_ack_o)
);

`default_nettype wire

// ==== tb_dm.sv ====
/*
 * directed testbench for the debug module top
 * clock, reset, instruction memory model, bus tasks, tests and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dm;

    localparam int CLK_PERIOD      = 4;
    localparam int MEM_WAIT_CYCLES = 4;
    localparam int NUM_TESTS       = 6;

    logic        clk_i;
    logic        rst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [7:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic [31:0] imem_addr_o;
    logic        imem_we_o;
    logic [31:0] imem_wdata_o;
    logic [31:0] imem_rdata_i;
    logic        haltreq_o;
    logic        resumereq_o;
    logic        ndmreset_o;
    logic        dmactive_o;

    // instruction memory model, word indexed
    logic [31:0] imem [0:255];
    int          we_count;
    int          errors;
    int          checks;
    // failures of the bound ack properties
    int          prop_errors;

    dm_top #(
        .MEM_WAIT_CYCLES (MEM_WAIT_CYCLES)
    ) dut0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .imem_addr_o  (imem_addr_o),
        .imem_we_o    (imem_we_o),
        .imem_wdata_o (imem_wdata_o),
        .imem_rdata_i (imem_rdata_i),
        .haltreq_o    (haltreq_o),
        .resumereq_o  (resumereq_o),
        .ndmreset_o   (ndmreset_o),
        .dmactive_o   (dmactive_o)
    );

    // combinational read at the low address bits
    assign imem_rdata_i = imem[imem_addr_o[7:0]];

    // memory writes and a count of write enable pulses
    always @(posedge clk_i)
    begin
        if (imem_we_o)
        begin
            imem[imem_addr_o[7:0]] <= imem_wdata_o;
            we_count <= we_count + 1;
        end
    end

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // watchdog, budget of 200 cycles per test
    initial
    begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display(">>> FAIL");
        $finish;
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERR %0t: %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] make_command(input logic [7:0] cmdtype,
                                                 input logic [2:0] size,
                                                 input logic write);
        dm_pkg::command_t cmd;
        cmd         = '0;
        cmd.cmdtype = cmdtype;
        cmd.aamsize = size;
        cmd.write   = write;
        return cmd;
    endfunction

    // cycles counts falling edges from the strobe until ack is seen
    task automatic wb_write(input logic [7:0] addr, input logic [31:0] data,
                            output int cycles);
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = addr;
        wb_dat_i = data;
        cycles   = 0;
        do
        begin
            @(negedge clk_i);
            cycles++;
        end
        while (!wb_ack_o);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        while (wb_ack_o)
            @(negedge clk_i);
    endtask

    task automatic wb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = addr;
        do
            @(negedge clk_i);
        while (!wb_ack_o);
        // read data is valid together with ack
        data     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        while (wb_ack_o)
            @(negedge clk_i);
    endtask

    task automatic test_reset_values();
        logic [31:0] rd;
        check_value({haltreq_o, resumereq_o, ndmreset_o, dmactive_o}, 0, "dmcontrol ports");
        check_value(imem_we_o, 0, "imem_we_o after reset");
        wb_read(8'h04, rd);
        check_value(rd, 0, "data0 after reset");
        wb_read(8'h05, rd);
        check_value(rd, 0, "data1 after reset");
        wb_read(8'h10, rd);
        check_value(rd, 0, "dmcontrol after reset");
        wb_read(8'h17, rd);
        check_value(rd, 0, "command after reset");
        check_value(we_count, 0, "write pulses after reset");
    endtask

    task automatic test_register_rw();
        logic [31:0]      v0;
        logic [31:0]      v1;
        logic [31:0]      rd;
        dm_pkg::command_t cmd;
        int               cyc;
        v0  = $urandom;
        v1  = $urandom;
        cmd = $urandom;
        // keep the random command away from the memory access type
        if (cmd.cmdtype == 8'd2)
            cmd.cmdtype = 8'd5;
        wb_write(8'h04, v0, cyc);
        wb_write(8'h05, v1, cyc);
        wb_write(8'h17, cmd, cyc);
        wb_read(8'h04, rd);
        check_value(rd, v0, "data0 readback");
        wb_read(8'h05, rd);
        check_value(rd, v1, "data1 readback");
        wb_read(8'h17, rd);
        check_value(rd, cmd, "command readback");
        // unknown index ignores the write and reads zero
        wb_write(8'h11, $urandom, cyc);
        check_value(cyc, 1, "unknown write ack delay");
        wb_read(8'h11, rd);
        check_value(rd, 0, "unknown address read");
    endtask

    task automatic test_dmcontrol();
        logic [31:0] v;
        logic [31:0] rd;
        int          cyc;
        v = $urandom;
        wb_write(8'h10, v, cyc);
        check_value(haltreq_o, v[31], "haltreq_o");
        check_value(resumereq_o, v[30], "resumereq_o");
        check_value(ndmreset_o, v[1], "ndmreset_o");
        check_value(dmactive_o, v[0], "dmactive_o");
        wb_read(8'h10, rd);
        check_value(rd, v, "dmcontrol readback");
    endtask

    task automatic test_mem_write();
        logic [31:0] addr;
        logic [31:0] v;
        int          we_before;
        int          cyc;
        addr = $urandom & 32'hff;
        v    = $urandom;
        wb_write(8'h05, addr, cyc);
        wb_write(8'h04, v, cyc);
        we_before = we_count;
        wb_write(8'h17, make_command(8'd2, 3'd2, 1'b1), cyc);
        check_value(imem[addr[7:0]], v, "memory word after write");
        check_value(we_count - we_before, 1, "write enable pulses");
    endtask

    task automatic test_mem_read();
        logic [31:0] addr;
        logic [31:0] v;
        logic [31:0] rd;
        int          cyc;
        addr = $urandom & 32'hff;
        v    = $urandom;
        imem[addr[7:0]] = v;
        wb_write(8'h05, addr, cyc);
        wb_write(8'h17, make_command(8'd2, 3'd2, 1'b0), cyc);
        check_value(cyc, MEM_WAIT_CYCLES + 2, "memory read ack delay");
        wb_read(8'h04, rd);
        check_value(rd, v, "data0 after memory read");
    endtask

    task automatic test_unsupported_cmd();
        logic [31:0] addr;
        logic [31:0] v;
        logic [31:0] rd;
        logic [31:0] mem_before;
        int          we_before;
        int          cyc;
        addr = $urandom & 32'hff;
        v    = $urandom;
        wb_write(8'h05, addr, cyc);
        wb_write(8'h04, v, cyc);
        mem_before = imem[addr[7:0]];
        we_before  = we_count;
        // other type as a write, then access memory with a 8 bit size as a read
        wb_write(8'h17, make_command(8'd3, 3'd2, 1'b1), cyc);
        check_value(cyc, 1, "other type ack delay");
        wb_write(8'h17, make_command(8'd2, 3'd0, 1'b0), cyc);
        check_value(cyc, 1, "other size ack delay");
        wb_read(8'h17, rd);
        check_value(rd, make_command(8'd2, 3'd0, 1'b0), "stored command");
        wb_read(8'h04, rd);
        check_value(rd, v, "data0 unchanged");
        check_value(imem[addr[7:0]], mem_before, "memory unchanged");
        check_value(we_count, we_before, "no write pulses");
    endtask

    initial
    begin
        errors   = 0;
        checks   = 0;
        we_count = 0;
        void'($urandom(32'hfbde));
        rst_i    = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        // fill pattern spans every address bit
        for (int i = 0; i < 256; i++)
            imem[i] = 32'h5a00_0000 ^ (i * 32'h0101_0101);
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        test_reset_values();
        test_register_rw();
        test_dmcontrol();
        test_mem_write();
        test_mem_read();
        test_unsupported_cmd();

        prop_errors = dut0.u_wb_slave.u_props.fail_count;
        $display("summary: %0d checks, %0d errors, %0d property failures",
                 checks, errors, prop_errors);
        if (errors == 0 && prop_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
dm_pkg.sv
dm_reg_if.sv
dm_mem_if.sv
dm_wb_slave.sv
dm_regfile.sv
dm_mem_access.sv
dm_top.sv
dm_props.sv
tb_dm.sv

// ==== Bender.yml ====
package:
  name: dm_wishbone

sources:
  - dm_pkg.sv
  - dm_reg_if.sv
  - dm_mem_if.sv
  - dm_wb_slave.sv
  - dm_regfile.sv
  - dm_mem_access.sv
  - dm_top.sv
  - target: test
    files:
      - dm_props.sv
      - tb_dm.sv
